// ==== filelist.f ====
verilog/iccm_pkg.sv
verilog/iccm_ram.sv
verilog/iccm_bank_select.sv
verilog/iccm_redundancy.sv
verilog/iccm_read_align.sv
verilog/iccm_mem.sv
sim/iccm_mem_props.sv
sim/tb_iccm_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ICCM testbench with Verilator

LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
   -f filelist.f --top-module tb_iccm_mem -Mdir obj_dir -o tb_iccm_mem
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_iccm_mem > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status, see $LOG"
   exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== sim/iccm_mem_props.sv ====
// ICCM assertions: read and write exclusion, known read data, write bank count, spare valid bits

module iccm_mem_props
   import iccm_pkg::*;
(
   input logic            clk,
   input logic            rst,
   input logic            wren,
   input logic            rden,
   input bank_vec_t       wren_bank,
   input logic [RD_W-1:0] rd_data,
   input logic [1:0]      red_valid    // Spare row valid bits
);

   timeunit 1ns;
   timeprecision 1ps;

   //************************************************************
   // Access rules
   //************************************************************

   a_rd_wr_excl : assert property (@(posedge clk) disable iff (rst)
      !(wren && rden))
      else $error("write enable and read enable are high in the same cycle");

   a_rd_known : assert property (@(posedge clk) disable iff (rst)
      rden |=> !$isunknown(rd_data))
      else $error("read data has unknown bits one cycle after a read");

   // A doubleword touches two banks at most
   a_wr_banks : assert property (@(posedge clk) disable iff (rst)
      $countones(wren_bank) <= 2)
      else $error("more than two bank write enables are high");

   //************************************************************
   // Spare row valid bits
   //************************************************************

   // Once set, a valid bit holds until reset
   a_valid_hold : assert property (@(posedge clk) disable iff (rst)
      (red_valid & $past(red_valid)) == $past(red_valid))
      else $error("a spare row valid bit fell outside reset");

   a_valid_rst : assert property (@(posedge clk)
      rst |=> (red_valid == 2'b00))
      else $error("a spare row valid bit is set in the cycle after reset");

endmodule

bind iccm_mem iccm_mem_props props_inst (
   .clk       (clk),
   .rst       (rst),
   .wren      (wren),
   .rden      (rden),
   .wren_bank (wren_bank),
   .rd_data   (rd_data),
   .red_valid (u_redundancy.red_valid)
);

// ==== sim/tb_iccm_mem.sv ====
// ICCM testbench with clock, reset, stimulus tasks, reference model, read checks and watchdog

module tb_iccm_mem
   import iccm_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ICCM_BITS  = ICCM_BITS_DEF;
   localparam int WA_W       = ICCM_BITS - 2;          // Word address width
   localparam int CLK_HALF   = 10;
   localparam int RST_CYCLES = 5;
   localparam int N_FILL     = 64;                     // Words 0..63 in 16 rows
   localparam int N_RAND_RD  = 40;
   localparam int N_DW       = 6;
   localparam int N_HALF     = 20;
   localparam int N_DIRECT   = 40;                     // Corrections, resets and their reads
   localparam int N_OPS      = N_FILL + N_RAND_RD + 3 * N_DW + N_HALF + N_DIRECT;
   localparam logic [1:0] SIZE_W = 2'b10;              // Word access

   logic                 clk;
   logic                 rst;
   logic                 wren;
   logic                 rden;
   logic [ICCM_BITS-1:1] rw_addr;
   logic                 buf_correct_ecc;
   logic [1:0]           wr_size;
   logic [WR_W-1:0]      wr_data;
   logic [RD_W-1:0]      rd_data;
   logic [WR_W-1:0]      rd_data_ecc;

   // Reference model of banks and spare rows
   word_t           mem_model [1 << WA_W];
   logic [WA_W-1:0] row_addr [2];
   word_t           row_data [2];
   logic [1:0]      row_valid;
   logic            row_lru;
   logic [31:0]     lfsr;

   iccm_mem #(.iccm_bits(ICCM_BITS)) iccm_mem_inst (
      .clk             (clk),
      .rst             (rst),
      .wren            (wren),
      .rden            (rden),
      .rw_addr         (rw_addr),
      .buf_correct_ecc (buf_correct_ecc),
      .wr_size         (wr_size),
      .wr_data         (wr_data),
      .rd_data         (rd_data),
      .rd_data_ecc     (rd_data_ecc)
   );

   initial clk = 1'b0;
   always #CLK_HALF clk = ~clk;

   //************************************************************
   // Helpers
   //************************************************************

   task automatic fail_stop(input string reason);
      $display("%s", reason);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   initial begin
      #(2 * CLK_HALF * (40 * N_OPS + 200));
      fail_stop("timeout: the test sequence did not complete in time");
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[62:0], lfsr[0]};     // One step per bit
      end
   endtask

   function automatic logic [ICCM_BITS-1:1] word_addr(input int w, input logic half);
      logic [WA_W-1:0] wa;
      wa = w[WA_W-1:0];
      return {wa, half};
   endfunction

   // Row 1 before row 0 before the bank
   function automatic word_t model_word(input logic [WA_W-1:0] w);
      if (row_valid[1] && row_addr[1] == w) return row_data[1];
      if (row_valid[0] && row_addr[0] == w) return row_data[0];
      return mem_model[w];
   endfunction

   task automatic model_write(input logic [ICCM_BITS-1:1] addr, input logic [1:0] size,
                              input logic [WR_W-1:0] data);
      logic [ICCM_BITS-1:1] nxt;
      logic [WA_W-1:0]      w;
      nxt = addr + ((size == SIZE_DW) ? (ICCM_BITS-1)'(2) : (ICCM_BITS-1)'(1));
      // Every written bank takes the row of rw_addr
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (addr[BANK_HI:2] == b[1:0] || nxt[BANK_HI:2] == b[1:0]) begin
            w            = {addr[ICCM_BITS-1:BANK_INDEX_LO], b[1:0]};
            mem_model[w] = b[0] ? data[WR_W-1:WORD_W] : data[WORD_W-1:0];
         end
      end
      for (int k = 0; k < 2; k++) begin
         if (row_valid[k] && addr[ICCM_BITS-1:3] == row_addr[k][WA_W-1:1] &&
             (addr[2] == row_addr[k][0] || size == SIZE_DW)) begin
            row_data[k] = row_addr[k][0] ? data[WR_W-1:WORD_W] : data[WORD_W-1:0];
         end
      end
   endtask

   //************************************************************
   // Bus operations on the falling edge
   //************************************************************

   task automatic apply_reset();
      rst = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      rst       = 1'b0;
      row_valid = 2'b00;
      row_lru   = 1'b0;
   endtask

   task automatic write_op(input logic [ICCM_BITS-1:1] addr, input logic [1:0] size,
                           input logic [WR_W-1:0] data);
      @(negedge clk);
      wren    = 1'b1;
      rw_addr = addr;
      wr_size = size;
      wr_data = data;
      model_write(addr, size, data);
      @(negedge clk);
      wren = 1'b0;
   endtask

   task automatic write_word(input int w, input word_t data);
      write_op(word_addr(w, 1'b0), SIZE_W, {data, data});
   endtask

   // Only the low word of wr_data goes into the row
   task automatic correct_op(input int w, input word_t data);
      @(negedge clk);
      buf_correct_ecc = 1'b1;
      rw_addr         = word_addr(w, 1'b0);
      wr_size         = SIZE_W;
      wr_data         = {~data, data};
      row_addr[row_lru]  = w[WA_W-1:0];
      row_valid[row_lru] = 1'b1;
      row_data[row_lru]  = data;
      row_lru            = ~row_lru;
      @(negedge clk);
      buf_correct_ecc = 1'b0;
   endtask

   task automatic read_check(input string name, input logic [ICCM_BITS-1:1] addr);
      logic [WA_W-1:0] w0;
      word_t           lo;
      word_t           hi;
      logic [RD_W-1:0] pre;
      logic [RD_W-1:0] exp_data;
      logic [WR_W-1:0] exp_ecc;
      w0       = addr[ICCM_BITS-1:2];
      lo       = model_word(w0);
      hi       = model_word(w0 + WA_W'(1));
      pre      = {hi[DATA_W-1:0], lo[DATA_W-1:0]};
      exp_data = addr[1] ? {16'b0, pre[RD_W-1:16]} : pre;   // Halfword start
      exp_ecc  = {hi, lo};
      @(negedge clk);
      rden    = 1'b1;
      rw_addr = addr;
      wr_size = SIZE_DW;
      @(negedge clk);                                         // One cycle latency
      assert (rd_data === exp_data) else
         fail_stop($sformatf("mismatch %s rd_data expected %h actual %h",
                             name, exp_data, rd_data));
      assert (rd_data_ecc === exp_ecc) else
         fail_stop($sformatf("mismatch %s rd_data_ecc expected %h actual %h",
                             name, exp_ecc, rd_data_ecc));
      rden = 1'b0;
   endtask

   //************************************************************
   // Test sequence
   //************************************************************

   initial begin
      logic [63:0] r;
      word_t       d0;
      word_t       d1;
      int          w;
      int          row;
      lfsr            = 32'h47e7;
      rst             = 1'b1;
      wren            = 1'b0;
      rden            = 1'b0;
      buf_correct_ecc = 1'b0;
      rw_addr         = '0;
      wr_size         = SIZE_W;
      wr_data         = '0;
      apply_reset();

      // Fill all four banks and read them aligned
      for (int i = 0; i < N_FILL; i++) begin
         rand_bits(WORD_W, r);
         write_word(i, r[WORD_W-1:0]);
      end
      for (int i = 0; i < N_RAND_RD; i++) begin
         rand_bits(6, r);
         w = int'(r[5:0]) % 63;                 // Next word stays filled
         read_check("word_rw", word_addr(w, 1'b0));
      end

      // Doubleword writes at bank 0, 2 and 3
      for (int i = 0; i < N_DW; i++) begin
         rand_bits(4, r);
         row = int'(r[3:0]) % 15;
         rand_bits(WORD_W, r);
         d0 = r[WORD_W-1:0];
         rand_bits(WORD_W, r);
         d1 = r[WORD_W-1:0];
         w  = row * 4 + ((i % 3 == 2) ? 3 : 2 * (i % 3));
         write_op(word_addr(w, 1'b0), SIZE_DW, {d1, d0});
         read_check("dw_write", word_addr(w, 1'b0));
         read_check("dw_write", word_addr(row * 4, 1'b0));   // Bank 0 of the written row
      end

      for (int i = 0; i < N_HALF; i++) begin
         rand_bits(6, r);
         w = int'(r[5:0]) % 63;
         read_check("halfword", word_addr(w, 1'b1));
      end

      // Correction into row 0 read as low and high word
      rand_bits(WORD_W, r);
      d0 = r[WORD_W-1:0];
      if (d0 == mem_model[21]) d0 = ~d0;
      correct_op(21, d0);
      read_check("correct", word_addr(21, 1'b0));
      read_check("correct", word_addr(20, 1'b0));
      read_check("correct", word_addr(21, 1'b1));
      read_check("correct", word_addr(20, 1'b1));

      // Writes over substituted words
      rand_bits(WORD_W, r);
      write_word(21, r[WORD_W-1:0]);
      read_check("row_update", word_addr(21, 1'b0));
      rand_bits(WORD_W, r);
      d0 = r[WORD_W-1:0];
      rand_bits(WORD_W, r);
      d1 = r[WORD_W-1:0];
      write_op(word_addr(20, 1'b0), SIZE_DW, {d1, d0});
      read_check("row_update", word_addr(20, 1'b0));
      rand_bits(WORD_W, r);
      correct_op(38, r[WORD_W-1:0]);            // Row 1
      read_check("row_update", word_addr(37, 1'b0));
      rand_bits(WORD_W, r);
      d0 = r[WORD_W-1:0];
      rand_bits(WORD_W, r);
      d1 = r[WORD_W-1:0];
      write_op(word_addr(38, 1'b0), SIZE_DW, {d1, d0});
      read_check("row_update", word_addr(37, 1'b0));
      read_check("row_update", word_addr(38, 1'b0));

      // LRU replacement and clearing by reset
      apply_reset();
      rand_bits(WORD_W, r);
      correct_op(5, r[WORD_W-1:0]);
      rand_bits(WORD_W, r);
      correct_op(26, r[WORD_W-1:0]);
      rand_bits(WORD_W, r);
      correct_op(47, r[WORD_W-1:0]);            // Takes row 0 from word 5
      read_check("lru_reset", word_addr(5, 1'b0));
      read_check("lru_reset", word_addr(26, 1'b0));
      read_check("lru_reset", word_addr(47, 1'b0));
      apply_reset();
      read_check("lru_reset", word_addr(26, 1'b0));
      read_check("lru_reset", word_addr(47, 1'b0));

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== verilog/iccm_bank_select.sv ====
// ICCM bank selector: address increment, per-bank enables, row addresses, write data steering

module iccm_bank_select
   import iccm_pkg::*;
#(
   parameter int iccm_bits = ICCM_BITS_DEF
) (
   input  logic                                            wren,
   input  logic                                            rden,
   input  logic [iccm_bits-1:1]                            rw_addr,    // Halfword address
   input  logic [1:0]                                      wr_size,
   input  logic [WR_W-1:0]                                 wr_data,
   output logic [iccm_bits-1:1]                            addr_inc,   // Next address
   output bank_vec_t                                       wren_bank,
   output bank_vec_t                                       rden_bank,
   output logic [NUM_BANKS-1:0][iccm_bits-1:BANK_INDEX_LO] addr_bank,
   output word_t [NUM_BANKS-1:0]                           bank_wr_data
);

   logic [1:0] incr;
   bank_vec_t  hit_cur;     // Bank holds word at rw_addr
   bank_vec_t  hit_next;    // Bank holds word at addr_inc

   //************************************************************
   // Next address
   //************************************************************

   assign incr     = (wr_size == SIZE_DW) ? 2'b10 : 2'b01;
   assign addr_inc = rw_addr + (iccm_bits-1)'(incr);   // Wraps into next row

   //************************************************************
   // Per-bank enables and row addresses
   //************************************************************

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign hit_cur[i]  = (rw_addr[BANK_HI:2] == (BANK_HI-1)'(i));
      assign hit_next[i] = (addr_inc[BANK_HI:2] == (BANK_HI-1)'(i));

      assign wren_bank[i] = wren & (hit_cur[i] | hit_next[i]);
      assign rden_bank[i] = rden & (hit_cur[i] | hit_next[i]);

      // A written bank takes the current row
      // a bank reached only by the increment takes the next row
      assign addr_bank[i] = wren_bank[i] ? rw_addr[iccm_bits-1:BANK_INDEX_LO] :
                            hit_next[i]  ? addr_inc[iccm_bits-1:BANK_INDEX_LO] :
                                           rw_addr[iccm_bits-1:BANK_INDEX_LO];

      // Even banks get the low word, odd banks the high word
      assign bank_wr_data[i] = wr_data[(i % 2)*WORD_W +: WORD_W];
   end

endmodule

// ==== verilog/iccm_mem.sv ====
// ICCM top level: bank selector, four bank RAMs, spare row redundancy and read alignment

module iccm_mem
   import iccm_pkg::*;
#(
   parameter int iccm_bits = ICCM_BITS_DEF
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wren,
   input  logic                 rden,
   input  logic [iccm_bits-1:1] rw_addr,
   input  logic                 buf_correct_ecc,
   input  logic [1:0]           wr_size,
   input  logic [WR_W-1:0]      wr_data,       // Low word even banks, high word odd
   output logic [RD_W-1:0]      rd_data,
   output logic [WR_W-1:0]      rd_data_ecc
);

   localparam int ROW_DEPTH = 1 << (iccm_bits - BANK_INDEX_LO);

   logic [iccm_bits-1:1]                            addr_inc;
   bank_vec_t                                       wren_bank;
   bank_vec_t                                       rden_bank;
   logic [NUM_BANKS-1:0][iccm_bits-1:BANK_INDEX_LO] addr_bank;
   word_t [NUM_BANKS-1:0]                           bank_wr_data;
   word_t [NUM_BANKS-1:0]                           bank_dout;
   bank_vec_t                                       sel_red0_q;
   bank_vec_t                                       sel_red1_q;
   word_t                                           red_data0;
   word_t                                           red_data1;

   iccm_bank_select #(.iccm_bits(iccm_bits)) u_bank_select (
      .wren         (wren),
      .rden         (rden),
      .rw_addr      (rw_addr),
      .wr_size      (wr_size),
      .wr_data      (wr_data),
      .addr_inc     (addr_inc),
      .wren_bank    (wren_bank),
      .rden_bank    (rden_bank),
      .addr_bank    (addr_bank),
      .bank_wr_data (bank_wr_data)
   );

   //************************************************************
   // Bank RAMs, enabled only by their own access
   //************************************************************

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      iccm_ram #(.depth(ROW_DEPTH)) u_ram (
         .clk (clk),
         .me  (wren_bank[i] | rden_bank[i]),
         .we  (wren_bank[i]),
         .adr (addr_bank[i]),
         .d   (bank_wr_data[i]),
         .q   (bank_dout[i])
      );
   end

   iccm_redundancy #(.iccm_bits(iccm_bits)) u_redundancy (
      .clk (clk), .rst (rst),
      .wren (wren), .rden (rden), .buf_correct_ecc (buf_correct_ecc),
      .rw_addr (rw_addr), .addr_inc (addr_inc),
      .wr_size (wr_size), .wr_data (wr_data),
      .sel_red0_q (sel_red0_q), .sel_red1_q (sel_red1_q),
      .red_data0 (red_data0), .red_data1 (red_data1)
   );

   iccm_read_align #(.iccm_bits(iccm_bits)) u_read_align (
      .clk (clk), .rst (rst),
      .rw_addr (rw_addr), .addr_inc (addr_inc), .bank_dout (bank_dout),
      .sel_red0_q (sel_red0_q), .sel_red1_q (sel_red1_q),
      .red_data0 (red_data0), .red_data1 (red_data1),
      .rd_data (rd_data), .rd_data_ecc (rd_data_ecc)
   );

endmodule

// ==== verilog/iccm_pkg.sv ====
// ICCM package: memory widths, bank layout constants, access size code, word and bank types

package iccm_pkg;

   //************************************************************
   // Memory geometry
   //************************************************************

   localparam int ICCM_BITS_DEF = 12;      // Byte address width, 4 KB
   localparam int NUM_BANKS     = 4;
   localparam int BANK_HI       = 3;       // Top bit of bank index
   localparam int BANK_INDEX_LO = 4;       // Row index starts here

   //************************************************************
   // Data widths
   //************************************************************

   localparam int WORD_W = 39;             // 32 data + 7 check bits
   localparam int DATA_W = 32;
   localparam int RD_W   = 64;             // Read data
   localparam int WR_W   = 78;             // Two stored words

   // Access size; any other code is a word
   localparam logic [1:0] SIZE_DW = 2'b11;

   //************************************************************
   // Types
   //************************************************************

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [NUM_BANKS-1:0] bank_vec_t;   // One bit per bank

endpackage

// ==== verilog/iccm_ram.sv ====
// ICCM bank RAM: behavioral single-port array with registered read

module iccm_ram
   import iccm_pkg::*;
#(
   parameter int depth = 256
) (
   input  logic                     clk,
   input  logic                     me,       // Bank access
   input  logic                     we,       // Write when accessed
   input  logic [$clog2(depth)-1:0] adr,
   input  word_t                    d,
   output word_t                    q
);

   word_t mem [depth];

   // One access per cycle
   // read data stays on q until the next read
   always_ff @(posedge clk) begin
      if (me) begin
         if (we) begin
            mem[adr] <= d;
         end else begin
            q <= mem[adr];
         end
      end
   end

endmodule

// ==== verilog/iccm_read_align.sv ====
// ICCM read alignment: read address registers, spare row mux, word pick and halfword shift

module iccm_read_align
   import iccm_pkg::*;
#(
   parameter int iccm_bits = ICCM_BITS_DEF
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [iccm_bits-1:1] rw_addr,
   input  logic [iccm_bits-1:1] addr_inc,
   input  word_t [NUM_BANKS-1:0] bank_dout,
   input  bank_vec_t            sel_red0_q,
   input  bank_vec_t            sel_red1_q,
   input  word_t                red_data0,
   input  word_t                red_data1,
   output logic [RD_W-1:0]      rd_data,
   output logic [WR_W-1:0]      rd_data_ecc
);

   logic [BANK_HI:1]      rd_addr_lo_q;   // Bank and halfword of low word
   logic [BANK_HI:2]      rd_addr_hi_q;   // Bank of high word
   word_t [NUM_BANKS-1:0] bank_fn;        // Bank output after substitution
   word_t                 word_lo;
   word_t                 word_hi;
   logic [RD_W-1:0]       rd_data_pre;

   //************************************************************
   // Read address registers
   //************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_addr_lo_q <= '0;
         rd_addr_hi_q <= '0;
      end else begin
         rd_addr_lo_q <= rw_addr[BANK_HI:1];
         rd_addr_hi_q <= addr_inc[BANK_HI:2];
      end
   end

   // Row 1 wins over row 0
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_fn
      assign bank_fn[i] = sel_red1_q[i] ? red_data1 :
                          sel_red0_q[i] ? red_data0 : bank_dout[i];
   end

   assign word_lo = bank_fn[rd_addr_lo_q[BANK_HI:2]];
   assign word_hi = bank_fn[rd_addr_hi_q];

   assign rd_data_pre = {word_hi[DATA_W-1:0], word_lo[DATA_W-1:0]};
   assign rd_data     = rd_addr_lo_q[1] ? {16'b0, rd_data_pre[RD_W-1:16]} :
                                          rd_data_pre;      // Halfword start
   assign rd_data_ecc = {word_hi, word_lo};                 // Raw check bits

endmodule

// ==== verilog/iccm_redundancy.sv ====
// ICCM redundancy: two spare rows with address, valid and data, LRU, match and read selects

module iccm_redundancy
   import iccm_pkg::*;
#(
   parameter int iccm_bits = ICCM_BITS_DEF
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wren,
   input  logic                 rden,
   input  logic                 buf_correct_ecc,   // Correction cycle
   input  logic [iccm_bits-1:1] rw_addr,
   input  logic [iccm_bits-1:1] addr_inc,
   input  logic [1:0]           wr_size,
   input  logic [WR_W-1:0]      wr_data,
   output bank_vec_t            sel_red0_q,
   output bank_vec_t            sel_red1_q,
   output word_t                red_data0,
   output word_t                red_data1
);

   logic [iccm_bits-1:2]   red_addr [2];        // Word address per row
   word_t                  red_data [2];
   logic [1:0]             red_valid;
   logic                   red_lru;             // Row to replace next
   logic [1:0][NUM_BANKS-1:0] sel_red;
   logic [1:0][NUM_BANKS-1:0] sel_red_q;
   logic                   is_dw;

   assign is_dw = (wr_size == SIZE_DW);

   //************************************************************
   // LRU
   //************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         red_lru <= 1'b0;
      end else if (buf_correct_ecc) begin
         red_lru <= ~red_lru;                   // Flip on every correction
      end
   end

   //************************************************************
   // Spare rows
   //************************************************************

   for (genvar k = 0; k < 2; k++) begin : g_row
      logic  row_load;     // Correction lands in this row
      logic  wr_hit;       // Write covers the stored word
      logic  take_hi;
      word_t row_din;

      assign row_load = buf_correct_ecc & (red_lru == 1'(k));

      // Doubleword address match, then word bit or a doubleword access
      assign wr_hit = wren & red_valid[k] &
                      (rw_addr[iccm_bits-1:3] == red_addr[k][iccm_bits-1:3]) &
                      ((rw_addr[2] == red_addr[k][2]) | is_dw);

      assign take_hi = red_addr[k][2] & (rw_addr[2] | is_dw);   // Odd word sits high
      assign row_din = (row_load | ~take_hi) ? wr_data[WORD_W-1:0] :
                                               wr_data[WR_W-1:WORD_W];

      always_ff @(posedge clk) begin
         if (rst) begin
            red_valid[k] <= 1'b0;
         end else if (row_load) begin
            red_valid[k] <= 1'b1;               // Stays set until reset
         end
      end

      always_ff @(posedge clk) begin
         if (row_load) begin
            red_addr[k] <= rw_addr[iccm_bits-1:2];
         end
         if (row_load | wr_hit) begin
            red_data[k] <= row_din;
         end
      end

      // Match per bank against both words of the access
      for (genvar i = 0; i < NUM_BANKS; i++) begin : g_match
         assign sel_red[k][i] = red_valid[k] &
            (((rw_addr[iccm_bits-1:2] == red_addr[k]) &
              (rw_addr[BANK_HI:2] == (BANK_HI-1)'(i))) |
             ((addr_inc[iccm_bits-1:2] == red_addr[k]) &
              (addr_inc[BANK_HI:2] == (BANK_HI-1)'(i))));
      end

      // Held with the RAM output until the next read
      always_ff @(posedge clk) begin
         if (rst) begin
            sel_red_q[k] <= '0;
         end else if (rden) begin
            sel_red_q[k] <= sel_red[k];
         end
      end
   end

   assign sel_red0_q = sel_red_q[0];
   assign sel_red1_q = sel_red_q[1];
   assign red_data0  = red_data[0];
   assign red_data1  = red_data[1];

endmodule
